// File: common/mdio_pkg.sv
`default_nettype none

package mdio_pkg;

	// one management operation as seen by the frame engine
	typedef struct packed {
		logic        write;    // 1 = write, 0 = read
		logic [4:0]  reg_addr;
		logic [15:0] wdata;
	} mdio_req_t;

	typedef struct packed {
		logic [15:0] rdata;    // zero after a write
	} mdio_rsp_t;

	// one entry of the bring-up list
	typedef struct packed {
		logic [4:0]  reg_addr;
		logic [15:0] data;
	} cfg_entry_t;

	localparam int CFG_LEN = 9; // entries in the config rom

	// clause 22 frame fields
	localparam logic [1:0] ST_BITS  = 2'b01;
	localparam logic [1:0] OP_WRITE = 2'b01;
	localparam logic [1:0] OP_READ  = 2'b10;
	localparam int TA_BITS      = 2;
	localparam int PREAMBLE_LEN = 32;

endpackage

`default_nettype wire

// File: source/phy_reset_seq.sv
`timescale 1ns/1ns
`default_nettype none

module phy_reset_seq #(
	parameter int RESET_HOLD = 1000,
	parameter int RESET_WAIT = 1000
) (
	input  logic clk,
	input  logic rst,
	output logic phy_rst_n,
	output logic cfg_start
);

	localparam int MAX_CNT = (RESET_HOLD > RESET_WAIT) ? RESET_HOLD : RESET_WAIT;
	localparam int CNT_W   = $clog2(MAX_CNT + 1);

	logic [CNT_W-1:0] cnt;

	// hold phase while phy_rst_n is low, wait phase until cfg_start
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt       <= '0;
			phy_rst_n <= 1'b0;
			cfg_start <= 1'b0;
		end else if (!phy_rst_n) begin
			if (cnt == CNT_W'(RESET_HOLD - 1)) begin
				phy_rst_n <= 1'b1; // release the phy
				cnt       <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end else if (!cfg_start) begin
			if (cnt == CNT_W'(RESET_WAIT - 1)) begin
				cfg_start <= 1'b1; // counter stops here for good
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: mdio_config/mdio_config_rom.sv
`timescale 1ns/1ns
`default_nettype none

module mdio_config_rom (
	input  logic                   clk,
	input  logic [3:0]             index,
	output mdio_pkg::cfg_entry_t   entry
);

	import mdio_pkg::*;

	// register 13 is the mmd access control, register 14 the address/data window
	localparam cfg_entry_t ROM [CFG_LEN] = '{
		'{5'd0,  16'h1200}, // autoneg enable and restart
		'{5'd13, 16'h001F}, // address mode
		'{5'd14, 16'h0032}, // rgmii control
		'{5'd13, 16'h401F}, // data mode without post increment
		'{5'd14, 16'h0000},
		'{5'd13, 16'h001F},
		'{5'd14, 16'h0031}, // cfg4
		'{5'd13, 16'h401F},
		'{5'd14, 16'h0080}  // normal operation
	};

	always_ff @(posedge clk) begin
		if (index < 4'(CFG_LEN)) begin
			entry <= ROM[index];
		end else begin
			entry <= '0; // past the end of the list
		end
	end

endmodule

`default_nettype wire

// File: mdio_config/mdio_config_seq.sv
`timescale 1ns/1ns
`default_nettype none

module mdio_config_seq #(
	parameter int PAUSE_CYCLES = 1000
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  cfg_start,
	output logic [3:0]            rom_index,
	input  mdio_pkg::cfg_entry_t  rom_entry,
	output mdio_pkg::mdio_req_t   req,
	output logic                  req_valid,
	input  logic                  req_ready,
	input  mdio_pkg::mdio_rsp_t   rsp,
	input  logic                  rsp_valid,
	input  mdio_pkg::mdio_req_t   host_req,
	input  logic                  host_req_valid,
	output logic                  host_req_ready,
	output mdio_pkg::mdio_rsp_t   host_rsp,
	output logic                  host_rsp_valid,
	output logic                  config_done
);

	import mdio_pkg::*;

	localparam int PC_W = $clog2(PAUSE_CYCLES + 1);

	typedef enum logic [2:0] {
		S_IDLE,
		S_FETCH,
		S_ISSUE,
		S_WAIT_RSP,
		S_PAUSE,
		S_HOST
	} state_t;

	state_t          state;
	logic [PC_W-1:0] pause_cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= S_IDLE;
			rom_index   <= '0;
			pause_cnt   <= '0;
			config_done <= 1'b0;
		end else begin
			case (state)
				S_IDLE: if (cfg_start) state <= S_FETCH;
				S_FETCH: state <= S_ISSUE; // rom output valid next cycle
				S_ISSUE: if (req_ready) state <= S_WAIT_RSP;
				S_WAIT_RSP: begin
					if (rsp_valid) begin
						state     <= S_PAUSE;
						pause_cnt <= '0;
					end
				end
				S_PAUSE: begin
					if (pause_cnt == PC_W'(PAUSE_CYCLES - 1)) begin
						if (rom_index == 4'(CFG_LEN - 1)) begin
							state       <= S_HOST;
							config_done <= 1'b1;
						end else begin
							rom_index <= rom_index + 1'b1;
							state     <= S_FETCH;
						end
					end else begin
						pause_cnt <= pause_cnt + 1'b1;
					end
				end
				S_HOST: state <= S_HOST; // stays until reset
				default: state <= S_IDLE;
			endcase
		end
	end

	// rom writes own the engine until host mode
	always_comb begin
		if (state == S_HOST) begin
			req            = host_req;
			req_valid      = host_req_valid;
			host_req_ready = req_ready;
		end else begin
			req.write      = 1'b1;
			req.reg_addr   = rom_entry.reg_addr;
			req.wdata      = rom_entry.data;
			req_valid      = (state == S_ISSUE);
			host_req_ready = 1'b0;
		end
	end

	assign host_rsp       = rsp;
	assign host_rsp_valid = rsp_valid && (state == S_HOST); // rom write responses stay internal

endmodule

`default_nettype wire

// File: mdio_engine/mdio_frame_engine.sv
`timescale 1ns/1ns
`default_nettype none

module mdio_frame_engine #(
	parameter logic [4:0] PHY_ADDR = 5'h00,
	parameter int         MDC_DIV  = 4
) (
	input  logic                 clk,
	input  logic                 rst,
	input  mdio_pkg::mdio_req_t  req,
	input  logic                 req_valid,
	output logic                 req_ready,
	output mdio_pkg::mdio_rsp_t  rsp,
	output logic                 rsp_valid,
	output logic                 mdc,
	output logic                 mdio_out,
	output logic                 mdio_oe,
	input  logic                 mdio_in
);

	import mdio_pkg::*;

	localparam int DIV_W      = (MDC_DIV > 2) ? $clog2(MDC_DIV) : 1;
	localparam int TA_START   = PREAMBLE_LEN + 14; // start, op, phy and reg address
	localparam int DATA_START = TA_START + TA_BITS;

	logic             busy;
	logic             is_read;
	logic [63:0]      shreg;
	logic [5:0]       bit_cnt;   // bit currently on the wire
	logic [DIV_W-1:0] div_cnt;
	logic [15:0]      rd_shift;
	logic             tick;
	logic             accept;

	assign accept    = req_valid && req_ready;
	assign tick      = busy && (div_cnt == DIV_W'(MDC_DIV - 1)); // mdc half period done
	assign req_ready = !busy && !rsp_valid;

	// control and mdc divider
	always_ff @(posedge clk) begin
		if (rst) begin
			busy      <= 1'b0;
			mdc       <= 1'b0;
			div_cnt   <= '0;
			bit_cnt   <= '0;
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= 1'b0;
			if (accept) begin
				busy    <= 1'b1;
				mdc     <= 1'b0;
				div_cnt <= DIV_W'(1); // handshake cycle counts as the first low cycle
				bit_cnt <= '0;
			end else if (busy) begin
				if (tick) begin
					div_cnt <= '0;
					mdc     <= !mdc;
					if (mdc) begin
						bit_cnt <= bit_cnt + 1'b1; // falling edge moves to the next bit
						if (bit_cnt == 6'd63) begin
							busy      <= 1'b0;
							rsp_valid <= 1'b1;
						end
					end
				end else begin
					div_cnt <= div_cnt + 1'b1;
				end
			end
		end
	end

	// frame shift out on falling mdc, read data in on rising mdc
	always_ff @(posedge clk) begin
		if (accept) begin
			is_read <= !req.write;
			shreg   <= {{PREAMBLE_LEN{1'b1}},
				ST_BITS,
				req.write ? OP_WRITE : OP_READ,
				PHY_ADDR,
				req.reg_addr,
				req.write ? TA_BITS'(2'b10) : TA_BITS'(2'b11),
				req.write ? req.wdata : 16'h0000};
		end else if (tick && mdc) begin
			shreg <= {shreg[62:0], 1'b1};
		end
		if (tick && !mdc && is_read && bit_cnt >= 6'(DATA_START)) begin
			rd_shift <= {rd_shift[14:0], mdio_in}; // msb first
		end
		if (tick && mdc && bit_cnt == 6'd63) begin
			rsp.rdata <= is_read ? rd_shift : 16'h0000;
		end
	end

	assign mdio_out = shreg[63];
	assign mdio_oe  = busy && !(is_read && bit_cnt >= 6'(TA_START)); // phy owns the bus after ta

endmodule

`default_nettype wire

// File: source/phy_mgmt_top.sv
`timescale 1ns/1ns
`default_nettype none

module phy_mgmt_top #(
	parameter logic [4:0] PHY_ADDR     = 5'h01,
	parameter int         MDC_DIV      = 25,
	parameter int         RESET_HOLD   = 28672,
	parameter int         RESET_WAIT   = 36864,
	parameter int         PAUSE_CYCLES = 1000
) (
	input  logic                 clk,
	input  logic                 rst,
	output logic                 mdc,
	inout  wire                  mdio,
	output logic                 phy_rst_n,
	output logic                 config_done,
	input  mdio_pkg::mdio_req_t  host_req,
	input  logic                 host_req_valid,
	output logic                 host_req_ready,
	output mdio_pkg::mdio_rsp_t  host_rsp,
	output logic                 host_rsp_valid
);

	import mdio_pkg::*;

	logic       cfg_start;
	logic [3:0] rom_index;
	cfg_entry_t rom_entry;
	mdio_req_t  req;
	logic       req_valid;
	logic       req_ready;
	mdio_rsp_t  rsp;
	logic       rsp_valid;
	logic       mdio_out;
	logic       mdio_oe;

	// tri-state pad with the pull-up on the board
	assign mdio = mdio_oe ? mdio_out : 1'bz;

	phy_reset_seq #(
		.RESET_HOLD (RESET_HOLD),
		.RESET_WAIT (RESET_WAIT)
	) u_reset_seq (
		.clk       (clk),
		.rst       (rst),
		.phy_rst_n (phy_rst_n),
		.cfg_start (cfg_start)
	);

	mdio_config_rom u_config_rom (
		.clk   (clk),
		.index (rom_index),
		.entry (rom_entry)
	);

	mdio_config_seq #(
		.PAUSE_CYCLES (PAUSE_CYCLES)
	) u_config_seq (
		.clk            (clk),
		.rst            (rst),
		.cfg_start      (cfg_start),
		.rom_index      (rom_index),
		.rom_entry      (rom_entry),
		.req            (req),
		.req_valid      (req_valid),
		.req_ready      (req_ready),
		.rsp            (rsp),
		.rsp_valid      (rsp_valid),
		.host_req       (host_req),
		.host_req_valid (host_req_valid),
		.host_req_ready (host_req_ready),
		.host_rsp       (host_rsp),
		.host_rsp_valid (host_rsp_valid),
		.config_done    (config_done)
	);

	mdio_frame_engine #(
		.PHY_ADDR (PHY_ADDR),
		.MDC_DIV  (MDC_DIV)
	) u_frame_engine (
		.clk       (clk),
		.rst       (rst),
		.req       (req),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.rsp       (rsp),
		.rsp_valid (rsp_valid),
		.mdc       (mdc),
		.mdio_out  (mdio_out),
		.mdio_oe   (mdio_oe),
		.mdio_in   (mdio)
	);

endmodule

`default_nettype wire

// File: dv/phy_mdio_model.sv
`timescale 1ns/1ns
`default_nettype none

module phy_mdio_model #(
	parameter logic [4:0] PHY_ADDR = 5'h01
) (
	input  wire phy_rst_n,
	input  wire mdc,
	inout  wire mdio
);

	import mdio_pkg::*;

	logic [15:0] regs [32];
	logic [15:0] ext_regs [64];  // small mmd map behind registers 13/14
	logic [5:0]  ext_addr;
	logic [25:0] wr_log [64];    // {phy, reg, data} of every write frame
	logic [5:0]  wr_count;
	logic        in_frame;
	logic [4:0]  pos;            // next bit counted from the start bit
	logic [31:0] shreg;
	logic [31:0] full;
	logic        rd_active;
	logic [15:0] rd_data;
	logic [15:0] rd_shift;
	logic        drive_en;
	logic        drive_val;

	assign mdio = drive_en ? drive_val : 1'bz;
	assign full = {shreg[30:0], mdio}; // whole frame while its last bit is on the wire

	// power-up state
	initial begin
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		for (int i = 0; i < 64; i++)
			ext_regs[i] = '1; // unwritten mmd space reads all ones
		ext_addr  = '0;
		wr_count  = '0;
		in_frame  = 1'b0;
		pos       = '0;
		shreg     = '0;
		rd_active = 1'b0;
		drive_en  = 1'b0;
		drive_val = 1'b1;
	end

	// frame decode on rising mdc
	always @(posedge mdc) begin
		if (!phy_rst_n) begin
			in_frame <= 1'b0; // phy in reset ignores the bus
		end else if (!in_frame) begin
			if (mdio == 1'b0) begin // first start bit ends the preamble
				in_frame <= 1'b1;
				pos      <= 5'd1;
				shreg    <= '0;
			end
		end else begin
			shreg <= {shreg[30:0], mdio};
			pos   <= pos + 5'd1;
			if (pos == 5'd14) begin // op, phy and reg are known here
				rd_active <= (shreg[11:10] == OP_READ) && (shreg[9:5] == PHY_ADDR);
				if (shreg[4:0] == 5'd14 && regs[13][15:14] != 2'b00)
					rd_data <= ext_regs[ext_addr];
				else
					rd_data <= regs[shreg[4:0]];
			end
			if (pos == 5'd31) begin
				in_frame  <= 1'b0;
				rd_active <= 1'b0;
				if (full[29:28] == OP_WRITE) begin
					wr_log[wr_count] <= {full[27:18], full[15:0]};
					wr_count         <= wr_count + 6'd1;
					if (full[27:23] == PHY_ADDR) begin
						regs[full[22:18]] <= full[15:0];
						if (full[22:18] == 5'd14) begin
							if (regs[13][15:14] == 2'b00)
								ext_addr <= full[5:0]; // address function
							else
								ext_regs[ext_addr] <= full[15:0];
						end
					end
				end
			end
		end
	end

	// read data goes out after falling mdc
	always @(negedge mdc) begin
		if (rd_active && pos == 5'd15) begin
			drive_en  <= 1'b1;
			drive_val <= 1'b0; // second turnaround bit
			rd_shift  <= rd_data;
		end else if (rd_active && pos >= 5'd16) begin
			drive_en  <= 1'b1;
			drive_val <= rd_shift[15];
			rd_shift  <= {rd_shift[14:0], 1'b0};
		end else begin
			drive_en <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: dv/tb_phy_mgmt.sv
`timescale 1ns/1ns
`default_nettype none

module tb_phy_mgmt;

	import mdio_pkg::*;

	localparam int         RESET_HOLD   = 20;
	localparam int         RESET_WAIT   = 30;
	localparam int         MDC_DIV      = 2;
	localparam int         PAUSE_CYCLES = 10;
	localparam logic [4:0] PHY_ADDR     = 5'h01;
	localparam int         FRAME_CYCLES = 128 * MDC_DIV;

	// mmd control words for devad 31 in address and data mode
	localparam logic [15:0] MMD_ADDR = 16'h001F;
	localparam logic [15:0] MMD_DATA = 16'h401F;
	localparam logic [20:0] CFG_EXPECT [CFG_LEN] = '{
		{5'd0, 16'h1200},   // autoneg enable and restart
		{5'd13, MMD_ADDR},
		{5'd14, 16'h0032},
		{5'd13, MMD_DATA},
		{5'd14, 16'h0000},
		{5'd13, MMD_ADDR},
		{5'd14, 16'h0031},
		{5'd13, MMD_DATA},
		{5'd14, 16'h0080}
	};

	logic      clk;
	logic      rst;
	logic      mdc;
	wire       mdio;
	logic      phy_rst_n;
	logic      config_done;
	mdio_req_t host_req;
	logic      host_req_valid;
	logic      host_req_ready;
	mdio_rsp_t host_rsp;
	logic      host_rsp_valid;

	pullup (mdio);

	phy_mgmt_top #(
		.PHY_ADDR     (PHY_ADDR),
		.MDC_DIV      (MDC_DIV),
		.RESET_HOLD   (RESET_HOLD),
		.RESET_WAIT   (RESET_WAIT),
		.PAUSE_CYCLES (PAUSE_CYCLES)
	) uut (
		.clk            (clk),
		.rst            (rst),
		.mdc            (mdc),
		.mdio           (mdio),
		.phy_rst_n      (phy_rst_n),
		.config_done    (config_done),
		.host_req       (host_req),
		.host_req_valid (host_req_valid),
		.host_req_ready (host_req_ready),
		.host_rsp       (host_rsp),
		.host_rsp_valid (host_rsp_valid)
	);

	phy_mdio_model #(
		.PHY_ADDR (PHY_ADDR)
	) model (
		.phy_rst_n (phy_rst_n),
		.mdc       (mdc),
		.mdio      (mdio)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic stop_run();
		$display("RESULT: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %0t ns: %s, expected 0x%0h, got 0x%0h",
				$time, what, expected, actual);
			stop_run();
		end
	endtask

	task automatic timed_out(input string what);
		$display("timeout while waiting for %s", what);
		stop_run();
	endtask

	task automatic step();
		@(posedge clk);
		#1; // inputs change just after the edge
	endtask

	task automatic reset_timing();
		int n;
		check("phy_rst_n after rst", 0, 32'(phy_rst_n));
		check("config_done after rst", 0, 32'(config_done));
		check("host_req_ready after rst", 0, 32'(host_req_ready));
		check("mdio released after rst", 1, 32'(mdio));
		n = 0;
		while (phy_rst_n !== 1'b1) begin
			step();
			n++;
			check("mdc idle in phy reset", 0, 32'(mdc));
			if (n > 4 * RESET_HOLD)
				timed_out("phy_rst_n release");
		end
		check("phy reset hold cycles", RESET_HOLD, n);
		repeat (RESET_WAIT) begin
			step();
			check("mdc idle in settle time", 0, 32'(mdc));
		end
	endtask

	task automatic config_writes();
		int cyc;
		int low_run;
		int frames;
		int last_start;
		cyc        = 0;
		low_run    = FRAME_CYCLES;
		frames     = 0;
		last_start = 0;
		while (config_done !== 1'b1) begin
			check("host port closed in config", 0, 32'(host_req_ready));
			step();
			cyc++;
			if (mdc === 1'b1 && low_run > 2 * MDC_DIV) begin // first mdc rise of a frame
				if (frames > 0)
					check("gap between rom frames", 1,
						32'(cyc - last_start >= FRAME_CYCLES + PAUSE_CYCLES));
				frames++;
				last_start = cyc;
			end
			low_run = (mdc === 1'b1) ? 0 : low_run + 1;
			if (cyc > 20 * CFG_LEN * FRAME_CYCLES)
				timed_out("config_done");
		end
		check("rom frames on the bus", CFG_LEN, frames);
		check("writes seen by the phy", CFG_LEN, 32'(model.wr_count));
		for (int i = 0; i < CFG_LEN; i++)
			check("config write", 32'({PHY_ADDR, CFG_EXPECT[i]}), 32'(model.wr_log[i]));
		check("mmd register 0x32", 0, 32'(model.ext_regs[6'h32]));
		check("mmd register 0x31", 32'h80, 32'(model.ext_regs[6'h31]));
	endtask

	task automatic host_op(input logic write, input logic [4:0] addr,
			input logic [15:0] wdata, output logic [15:0] rdata);
		int n;
		host_req.write    = write;
		host_req.reg_addr = addr;
		host_req.wdata    = wdata;
		host_req_valid    = 1'b1;
		n = 0;
		while (host_req_ready !== 1'b1) begin
			step();
			n++;
			if (n > 4 * FRAME_CYCLES)
				timed_out("host_req_ready");
		end
		step(); // handshake on this edge
		host_req_valid = 1'b0;
		n = 0;
		while (host_rsp_valid !== 1'b1) begin
			step();
			n++;
			if (n > 4 * FRAME_CYCLES)
				timed_out("host_rsp_valid");
		end
		rdata = host_rsp.rdata;
	endtask

	task automatic write_read_back();
		logic [4:0]  addr [6];
		logic [15:0] shadow [32];
		logic [15:0] rdata;
		int          r;
		for (int i = 0; i < 6; i++) begin
			r = $urandom_range(29, 0);
			addr[i] = 5'((r >= 13) ? r + 2 : r); // skip the mmd window
			shadow[addr[i]] = 16'($urandom);
			host_op(1'b1, addr[i], shadow[addr[i]], rdata);
			check("host write response", 0, 32'(rdata));
		end
		for (int i = 0; i < 6; i++) begin
			host_op(1'b0, addr[i], 16'h0000, rdata);
			check("host read back", 32'(shadow[addr[i]]), 32'(rdata));
		end
		host_op(1'b0, 5'd14, 16'h0000, rdata); // data mode still points at 0x31
		check("mmd 0x31 through register 14", 32'h80, 32'(rdata));
	endtask

	task automatic back_pressure();
		mdio_req_t   reqs [4];
		logic [15:0] expect_rsp [4];
		logic [15:0] d0;
		logic [15:0] d1;
		int          accept_cyc [4];
		int          sent;
		int          got;
		int          cyc;
		bit          ready_now;
		d0         = 16'($urandom);
		d1         = 16'($urandom);
		reqs[0]    = '{1'b1, 5'd3, d0};
		reqs[1]    = '{1'b1, 5'd4, d1};
		reqs[2]    = '{1'b0, 5'd3, 16'h0000};
		reqs[3]    = '{1'b0, 5'd4, 16'h0000};
		expect_rsp = '{16'h0000, 16'h0000, d0, d1};
		sent = 0;
		got  = 0;
		cyc  = 0;
		host_req       = reqs[0];
		host_req_valid = 1'b1; // held high across every busy frame
		while (got < 4) begin
			check("ready low while a response is out", 0,
				32'(host_req_ready && host_rsp_valid));
			ready_now = host_req_valid && host_req_ready;
			step();
			cyc++;
			if (ready_now) begin
				check("accept after previous response", sent, got);
				accept_cyc[sent] = cyc - 1;
				sent++;
				if (sent < 4)
					host_req = reqs[sent];
				else
					host_req_valid = 1'b0;
			end
			if (host_rsp_valid) begin
				check("response has a request", 1, 32'(got < sent));
				check("response in request order", 32'(expect_rsp[got]), 32'(host_rsp.rdata));
				check("frame latency", FRAME_CYCLES, cyc - accept_cyc[got]);
				got++;
			end
			if (cyc > 8 * FRAME_CYCLES)
				timed_out("back-pressure responses");
		end
		repeat (2 * FRAME_CYCLES) begin
			step();
			check("no extra response", 0, 32'(host_rsp_valid));
		end
	endtask

	initial begin
		void'($urandom(32'h401c_4422));
		rst            = 1'b1;
		host_req       = '0;
		host_req_valid = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		reset_timing();
		config_writes();
		write_read_back();
		back_pressure();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
common/mdio_pkg.sv
source/phy_reset_seq.sv
mdio_config/mdio_config_rom.sv
mdio_config/mdio_config_seq.sv
mdio_engine/mdio_frame_engine.sv
source/phy_mgmt_top.sv
dv/phy_mdio_model.sv
dv/tb_phy_mgmt.sv

// File: Makefile
# Verilator simulation of the PHY management subsystem

VERILATOR ?= verilator
TOP       ?= tb_phy_mgmt
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
